// File: build.f
uart_pkg.sv
sync_fifo.sv
uart_transmit.sv
uart_receive.sv
uart_regs.sv
uart.sv
uart_assert.sv
uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the serial port testbench with Verilator and runs it

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    --top-module uart_tb \
    -f build.f \
    -o uart_sim &&
./obj_dir/uart_sim ||
{
    echo "Build or simulation failed"
    exit 1
}

// File: sync_fifo.sv
// Synchronous circular-buffer FIFO with empty and almost-full flags
`timescale 1ns/1ns

module sync_fifo
    import uart_pkg::*;
    #(
        parameter int width = 9,
        parameter int size = fifo_length,
        parameter int almost_full_threshold = rx_fifo_threshold
    )
    (
        input  logic             clk,
        input  logic             reset,
        input  logic             enqueue_en,
        input  logic [width-1:0] value_in,
        input  logic             dequeue_en,
        output logic [width-1:0] value_out,
        output logic             empty,
        output logic             almost_full
    );

    localparam int ptr_width = $clog2(size);
    localparam int count_width = $clog2(size + 1);

    logic [width-1:0] storage[size];
    logic [ptr_width-1:0] read_ptr;
    logic [ptr_width-1:0] write_ptr;
    logic [count_width-1:0] count;
    logic full;
    logic do_enqueue;
    logic do_dequeue;

    assign empty = count == '0;
    assign full = count == count_width'(size);
    assign almost_full = count >= count_width'(almost_full_threshold);

    // A pop on an empty buffer is ignored so the count cannot wrap
    assign do_dequeue = dequeue_en && !empty;

    // A push into a full buffer only lands if a pop frees a slot in the same cycle
    assign do_enqueue = enqueue_en && (!full || do_dequeue);

    // The head entry is shown straight from storage
    assign value_out = storage[read_ptr];

    // Storage holds payload only and is never cleared
    always_ff @(posedge clk)
    begin
        if (do_enqueue)
            storage[write_ptr] <= value_in;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            read_ptr <= '0;
            write_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_enqueue)
            begin
                // Pointers wrap explicitly so a size that is not a power of two works
                if (write_ptr == ptr_width'(size - 1))
                    write_ptr <= '0;
                else
                    write_ptr <= write_ptr + 1'b1;
            end

            if (do_dequeue)
            begin
                if (read_ptr == ptr_width'(size - 1))
                    read_ptr <= '0;
                else
                    read_ptr <= read_ptr + 1'b1;
            end

            // Simultaneous push and pop leave the count unchanged
            if (do_enqueue && !do_dequeue)
                count <= count + 1'b1;
            else if (do_dequeue && !do_enqueue)
                count <= count - 1'b1;
        end
    end

endmodule

// File: uart.sv
// Top level of the memory-mapped serial port
`timescale 1ns/1ns

module uart
    import uart_pkg::*;
    (
        input  logic                  clk,
        input  logic                  reset,
        input  logic [addr_width-1:0] address,
        input  logic                  read_en,
        input  logic                  write_en,
        input  logic [data_width-1:0] write_data,
        output logic [data_width-1:0] read_data,
        output logic                  rx_interrupt,
        output logic                  uart_tx,
        input  logic                  uart_rx
    );

    logic tx_en;
    logic [7:0] tx_char;
    logic tx_ready;
    logic [divisor_width-1:0] clocks_per_bit;
    logic rx_char_valid;
    logic [7:0] rx_char;
    logic rx_frame_error;
    logic dequeue_en;
    logic fifo_empty;
    logic fifo_almost_full;
    logic [7:0] fifo_char;
    logic fifo_frame_error;

    uart_regs uart_regs(.*);

    uart_transmit uart_transmit(.*);

    uart_receive uart_receive(.*);

    // Each entry is the frame error bit above the character
    sync_fifo #(
        .width(9),
        .size(fifo_length),
        .almost_full_threshold(rx_fifo_threshold)
    ) rx_fifo(
        .clk(clk),
        .reset(reset),
        .enqueue_en(rx_char_valid),
        .value_in({rx_frame_error, rx_char}),
        .dequeue_en(dequeue_en),
        .value_out({fifo_frame_error, fifo_char}),
        .empty(fifo_empty),
        .almost_full(fifo_almost_full)
    );

endmodule

// File: uart_assert.sv
// Concurrent checks on the transmitter line, the receive interrupt and the reset state
`timescale 1ns/1ns

module uart_assert
    #(
        // Each bound copy checks only the signals its host really has
        parameter bit check_transmit = 1'b1,
        parameter bit check_interrupt = 1'b1
    )
    (
        input logic clk,
        input logic reset,
        input logic tx_ready,
        input logic uart_tx,
        input logic rx_char_valid,
        input logic rx_interrupt
    );

    generate
        if (check_transmit)
        begin : line_checks
            // An idle transmitter keeps the line at the stop level
            idle_line_high: assert property (@(posedge clk) disable iff (reset)
                tx_ready |-> uart_tx)
                else $error("uart_tx is low while tx_ready is high");

            // The transmitter leaves reset ready
            ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> tx_ready)
                else $error("tx_ready is low in the first cycle after reset");
        end

        if (check_interrupt)
        begin : interrupt_checks
            // A character entering the FIFO leaves it non-empty, so the interrupt is up
            interrupt_on_enqueue: assert property (@(posedge clk) disable iff (reset)
                rx_char_valid |=> rx_interrupt)
                else $error("rx_interrupt is low after a character entered the FIFO");
        end
    endgenerate

endmodule

// The transmitter copy watches the serial line and tx_ready
bind uart_transmit uart_assert #(.check_interrupt(1'b0)) transmit_checks(
    .clk(clk),
    .reset(reset),
    .tx_ready(tx_ready),
    .uart_tx(uart_tx),
    .rx_char_valid(),
    .rx_interrupt()
);

// The top-level copy watches the receive interrupt
bind uart uart_assert #(.check_transmit(1'b0)) top_checks(
    .clk(clk),
    .reset(reset),
    .tx_ready(),
    .uart_tx(),
    .rx_char_valid(rx_char_valid),
    .rx_interrupt(rx_interrupt)
);

// File: uart_pkg.sv
// Shared register map, bus widths and receive FIFO sizing for the serial port
package uart_pkg;

    // Bus widths seen by the register block
    localparam int data_width = 32;
    localparam int addr_width = 32;

    // Base of the register block on the I/O bus
    localparam logic [addr_width-1:0] base_address = 32'h0000_0000;

    // Register offsets, one word apart
    localparam logic [addr_width-1:0] status_reg = base_address + 32'd0;
    localparam logic [addr_width-1:0] rx_reg = base_address + 32'd4;
    localparam logic [addr_width-1:0] tx_reg = base_address + 32'd8;
    localparam logic [addr_width-1:0] divisor_reg = base_address + 32'd12;

    // Width of the clocks-per-bit divisor
    localparam int divisor_width = 16;

    // Number of receive FIFO entries
    localparam int fifo_length = 8;

    // Fill level at which a new character forces the oldest one out
    localparam int rx_fifo_threshold = fifo_length - 1;

endpackage

// File: uart_receive.sv
// Serial receiver that samples each bit at its centre and flags a bad stop bit
`timescale 1ns/1ns

module uart_receive
    import uart_pkg::*;
    (
        input  logic                     clk,
        input  logic                     reset,
        input  logic                     uart_rx,
        input  logic [divisor_width-1:0] clocks_per_bit,
        output logic                     rx_char_valid,
        output logic [7:0]               rx_char,
        output logic                     rx_frame_error
    );

    typedef enum logic [1:0]
    {
        state_idle,
        state_start,
        state_data,
        state_stop
    } receive_state_t;

    receive_state_t state;

    // Two-flop synchronizer plus one more flop for edge detection
    logic rx_meta;
    logic rx_sync;
    logic rx_last;
    logic start_edge;

    // Cycles left until the next sample point
    logic [divisor_width-1:0] clock_count;

    // Index of the data bit being received
    logic [2:0] bit_count;

    assign start_edge = rx_last && !rx_sync;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            // The line idles high, so the synchronizer starts there too
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end
        else
        begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= state_idle;
            clock_count <= '0;
            bit_count <= '0;
            rx_char_valid <= 1'b0;
        end
        else
        begin
            // The valid strobe lasts a single cycle
            rx_char_valid <= 1'b0;

            case (state)
                state_idle:
                begin
                    if (start_edge)
                    begin
                        // Wait half a bit to land in the middle of the start bit
                        clock_count <= clocks_per_bit >> 1;
                        state <= state_start;
                    end
                end

                state_start:
                begin
                    if (clock_count != '0)
                        clock_count <= clock_count - 1'b1;
                    else if (rx_sync)
                    begin
                        // Line went high again, treat it as a glitch
                        state <= state_idle;
                    end
                    else
                    begin
                        clock_count <= clocks_per_bit - 1'b1;
                        bit_count <= '0;
                        state <= state_data;
                    end
                end

                state_data:
                begin
                    if (clock_count != '0)
                        clock_count <= clock_count - 1'b1;
                    else
                    begin
                        clock_count <= clocks_per_bit - 1'b1;
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == 3'd7)
                            state <= state_stop;
                    end
                end

                state_stop:
                begin
                    if (clock_count != '0)
                        clock_count <= clock_count - 1'b1;
                    else
                    begin
                        // Report the character whatever the stop bit looked like
                        rx_char_valid <= 1'b1;
                        state <= state_idle;
                    end
                end

                default:
                    state <= state_idle;
            endcase
        end
    end

    // Payload registers, only meaningful while rx_char_valid is high
    always_ff @(posedge clk)
    begin
        // Data arrives LSB first, so shift in from the top
        if (state == state_data && clock_count == '0)
            rx_char <= {rx_sync, rx_char[7:1]};

        // A low stop bit marks this character as badly framed
        if (state == state_stop && clock_count == '0)
            rx_frame_error <= !rx_sync;
    end

endmodule

// File: uart_regs.sv
// Register block with address decode, divisor, overrun flag and registered read data
`timescale 1ns/1ns

module uart_regs
    import uart_pkg::*;
    (
        input  logic                     clk,
        input  logic                     reset,
        input  logic [addr_width-1:0]    address,
        input  logic                     read_en,
        input  logic                     write_en,
        input  logic [data_width-1:0]    write_data,
        output logic [data_width-1:0]    read_data,
        input  logic                     tx_ready,
        input  logic                     fifo_empty,
        input  logic                     fifo_almost_full,
        input  logic [7:0]               fifo_char,
        input  logic                     fifo_frame_error,
        input  logic                     rx_char_valid,
        output logic                     tx_en,
        output logic [7:0]               tx_char,
        output logic [divisor_width-1:0] clocks_per_bit,
        output logic                     dequeue_en,
        output logic                     rx_interrupt
    );

    logic rx_read;
    logic overrun_drop;
    logic overrun;
    logic head_frame_error;

    // A write to the transmit register loads the transmitter in the same cycle
    assign tx_en = write_en && address == tx_reg;
    assign tx_char = write_data[7:0];

    // Reading the receive register pops the character it returns
    assign rx_read = read_en && address == rx_reg;

    // A character arriving at the threshold pushes the oldest one out
    assign overrun_drop = rx_char_valid && fifo_almost_full;
    assign dequeue_en = rx_read || overrun_drop;

    assign rx_interrupt = !fifo_empty;

    // The head entry is stale when the FIFO is empty
    assign head_frame_error = fifo_frame_error && !fifo_empty;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            clocks_per_bit <= divisor_width'(1);
        else if (write_en && address == divisor_reg)
            clocks_per_bit <= write_data[divisor_width-1:0];
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            overrun <= 1'b0;
        else if (overrun_drop)
        begin
            // Set takes priority over a clear in the same cycle
            overrun <= 1'b1;
        end
        else if (rx_read)
            overrun <= 1'b0;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_data <= '0;
        else if (read_en)
        begin
            if (address == status_reg)
            begin
                read_data <= {{(data_width - 4){1'b0}}, head_frame_error, overrun,
                    !fifo_empty, tx_ready};
            end
            else
            begin
                // Every other address returns the FIFO head character
                read_data <= {{(data_width - 8){1'b0}}, fifo_char};
            end
        end
    end

endmodule

// File: uart_tb.sv
// Testbench for the serial port with loopback, a serial line driver and a FIFO reference model
`timescale 1ns/1ns

module uart_tb
    import uart_pkg::*;
    ();

    logic clk;
    logic reset;
    logic [addr_width-1:0] address;
    logic read_en;
    logic write_en;
    logic [data_width-1:0] write_data;
    logic [data_width-1:0] read_data;
    logic rx_interrupt;
    logic uart_tx;
    logic uart_rx;

    // Line select for the receiver, low gives loopback from uart_tx
    logic use_driver;
    logic driver_line;

    // Bit time in clocks, kept equal to the programmed divisor
    int bit_cycles;

    int seed;
    int chars_received;
    int rx_target;

    // Reference FIFO, each entry is the frame error bit above the character
    logic [8:0] model_fifo[$];
    logic model_overrun;

    // Handoff from the bus read task to the checking process
    event read_done;
    string read_name;
    logic [addr_width-1:0] read_address;
    logic [data_width-1:0] read_value;

    logic [7:0] tx_byte;
    logic [9:0] frame_bits;

    uart uut(
        .clk(clk),
        .reset(reset),
        .address(address),
        .read_en(read_en),
        .write_en(write_en),
        .write_data(write_data),
        .read_data(read_data),
        .rx_interrupt(rx_interrupt),
        .uart_tx(uart_tx),
        .uart_rx(uart_rx)
    );

    assign uart_rx = use_driver ? driver_line : uart_tx;

    always #10 clk = ~clk;

    // Counts received characters, sampled away from the active edge
    always @(negedge clk)
    begin
        if (uut.rx_char_valid)
            chars_received <= chars_received + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Simulation FAILED");
        $fatal(1, "Wait limit reached");
    endtask

    // Expected read data from the model, with the transmitter assumed idle
    function automatic logic [31:0] expected_read(input logic [addr_width-1:0] addr);
        logic [8:0] head;
        logic available;
        available = model_fifo.size() > 0;
        head = available ? model_fifo[0] : 9'd0;
        if (addr == status_reg)
            expected_read = {28'd0, head[8], model_overrun, available, 1'b1};
        else
            expected_read = {24'd0, head[7:0]};
    endfunction

    // A new character at the threshold pushes the oldest one out
    task automatic model_enqueue(input logic [8:0] entry);
        if (model_fifo.size() >= rx_fifo_threshold)
        begin
            void'(model_fifo.pop_front());
            model_overrun = 1'b1;
        end
        model_fifo.push_back(entry);
    endtask

    // Compares every checked read and then applies the pop of an rx_reg read
    always @(read_done)
    begin
        check_value(read_name, expected_read(read_address), read_value);
        if (read_address == rx_reg)
        begin
            if (model_fifo.size() > 0)
                void'(model_fifo.pop_front());
            model_overrun = 1'b0;
        end
    end

    task automatic bus_write(input logic [addr_width-1:0] addr,
        input logic [data_width-1:0] data);
        @(negedge clk);
        address = addr;
        write_data = data;
        write_en = 1'b1;
        @(negedge clk);
        write_en = 1'b0;
    endtask

    // Read data is registered, so it is taken one cycle after read_en
    task automatic bus_read(input logic [addr_width-1:0] addr,
        output logic [data_width-1:0] data);
        @(negedge clk);
        address = addr;
        read_en = 1'b1;
        @(negedge clk);
        read_en = 1'b0;
        data = read_data;
    endtask

    task automatic checked_read(input string name, input logic [addr_width-1:0] addr);
        logic [data_width-1:0] data;
        bus_read(addr, data);
        read_name = name;
        read_address = addr;
        read_value = data;
        -> read_done;
    endtask

    // Polls status until any bit of the mask is set
    task automatic wait_status(input logic [data_width-1:0] mask, input string what);
        logic [data_width-1:0] data;
        int polls;
        polls = 0;
        bus_read(status_reg, data);
        while ((data & mask) == '0)
        begin
            polls++;
            if (polls > 1000)
                report_timeout(what);
            bus_read(status_reg, data);
        end
    endtask

    // Waits for the receiver to report the next character
    task automatic wait_received();
        int cycles;
        cycles = 0;
        rx_target++;
        while (chars_received < rx_target)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 3000)
                report_timeout("a received character");
        end
    endtask

    // Drives one frame onto the line with a chosen stop bit, then an idle bit time
    task automatic send_frame(input logic [7:0] value, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            driver_line = frame[i];
            repeat (bit_cycles - 1) @(negedge clk);
        end
        @(negedge clk);
        driver_line = 1'b1;
        repeat (bit_cycles) @(negedge clk);
    endtask

    // Samples uart_tx at the centre of each bit of the next frame
    task automatic decode_frame(output logic [9:0] bits);
        int cycles;
        cycles = 0;
        while (uart_tx !== 1'b0)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 3000)
                report_timeout("a start bit on uart_tx");
        end
        repeat (bit_cycles / 2) @(negedge clk);
        for (int i = 0; i < 10; i++)
        begin
            bits[i] = uart_tx;
            check_value("tx_ready low during frame", 32'd0, 32'(uut.tx_ready));
            repeat (bit_cycles) @(negedge clk);
        end
    endtask

    // Sends one byte through loopback and records it in the model
    task automatic loop_byte(input logic [7:0] value);
        wait_status(32'h1, "transmitter ready");
        bus_write(tx_reg, {24'd0, value});
        wait_received();
        model_enqueue({1'b0, value});
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        address = '0;
        read_en = 1'b0;
        write_en = 1'b0;
        write_data = '0;
        use_driver = 1'b0;
        driver_line = 1'b1;
        bit_cycles = 1;
        seed = 38;
        rx_target = 0;
        model_overrun = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Reset state
        checked_read("reset status", status_reg);
        check_value("reset rx_interrupt", 32'd0, 32'(rx_interrupt));
        check_value("reset uart_tx", 32'd1, 32'(uart_tx));

        // Transmit format with the receiver held on an idle line
        use_driver = 1'b1;
        bus_write(divisor_reg, 32'd5);
        bit_cycles = 5;
        tx_byte = 8'($random(seed));
        bus_write(tx_reg, {24'd0, tx_byte});
        decode_frame(frame_bits);
        check_value("transmit start bit", 32'd0, 32'(frame_bits[0]));
        check_value("transmit data bits", 32'(tx_byte), 32'(frame_bits[8:1]));
        check_value("transmit stop bit", 32'd1, 32'(frame_bits[9]));
        wait_status(32'h1, "transmitter ready after frame");
        checked_read("status after transmit", status_reg);

        // Loopback of single bytes
        use_driver = 1'b0;
        bus_write(divisor_reg, 32'd7);
        bit_cycles = 7;
        for (int n = 0; n < 20; n++)
        begin
            loop_byte(8'($random(seed)));
            wait_status(32'h2, "receive data available");
            check_value("rx_interrupt with data", 32'd1, 32'(rx_interrupt));
            wait_status(32'h1, "transmitter ready after loopback");
            checked_read("loopback status", status_reg);
            checked_read("loopback character", rx_reg);
        end
        check_value("rx_interrupt after loopback", 32'd0, 32'(rx_interrupt));

        // Framing error from a low stop bit, then a good frame
        use_driver = 1'b1;
        tx_byte = 8'($random(seed));
        send_frame(tx_byte, 1'b0);
        wait_received();
        model_enqueue({1'b1, tx_byte});
        checked_read("framing error status", status_reg);
        checked_read("framing error character", rx_reg);
        tx_byte = 8'($random(seed));
        send_frame(tx_byte, 1'b1);
        wait_received();
        model_enqueue({1'b0, tx_byte});
        checked_read("good frame status", status_reg);
        checked_read("good frame character", rx_reg);
        use_driver = 1'b0;

        // Overrun keeps only the newest characters
        for (int n = 0; n < 10; n++)
            loop_byte(8'($random(seed)));
        wait_status(32'h1, "transmitter ready after burst");
        checked_read("overrun status", status_reg);
        for (int n = 0; n < rx_fifo_threshold; n++)
        begin
            checked_read("drained character", rx_reg);
            if (n == 0)
                checked_read("status after first drain read", status_reg);
        end
        checked_read("status after drain", status_reg);
        check_value("rx_interrupt after drain", 32'd0, 32'(rx_interrupt));

        // The checking process compares the last read in this time step
        @(negedge clk);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: uart_transmit.sv
// Serial transmitter that sends start, eight data and one stop bit per character
`timescale 1ns/1ns

module uart_transmit
    import uart_pkg::*;
    (
        input  logic                     clk,
        input  logic                     reset,
        input  logic                     tx_en,
        input  logic [7:0]               tx_char,
        input  logic [divisor_width-1:0] clocks_per_bit,
        output logic                     tx_ready,
        output logic                     uart_tx
    );

    // Frame bits still to go out, bit 0 is the one on the line now
    logic [9:0] shift_frame;

    // Cycles left in the current bit time
    logic [divisor_width-1:0] clock_count;

    // Bit boundaries left after the current bit
    logic [3:0] bit_count;

    // The line comes straight off a flop, so it cannot glitch
    assign uart_tx = shift_frame[0];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            // All ones keeps the line at the idle level
            shift_frame <= '1;
            clock_count <= '0;
            bit_count <= '0;
            tx_ready <= 1'b1;
        end
        else if (tx_ready)
        begin
            // A load while busy is dropped, since this branch only runs when idle
            if (tx_en)
            begin
                // Stop bit, character LSB first, then the start bit on the line
                shift_frame <= {1'b1, tx_char, 1'b0};
                clock_count <= clocks_per_bit - 1'b1;
                bit_count <= 4'd9;
                tx_ready <= 1'b0;
            end
        end
        else if (clock_count == '0)
        begin
            // End of one bit time
            if (bit_count == '0)
            begin
                // The stop bit has now lasted a full bit time
                tx_ready <= 1'b1;
            end
            else
            begin
                // Shift in ones so the line ends up idle after the stop bit
                shift_frame <= {1'b1, shift_frame[9:1]};
                bit_count <= bit_count - 1'b1;
                clock_count <= clocks_per_bit - 1'b1;
            end
        end
        else
            clock_count <= clock_count - 1'b1;
    end

endmodule
